// ==== logic/ascii_hex_decode.sv ====
module ascii_hex_decode
   import ble_rx_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_line_ready,
   input  window_t i_window,
   output logic    o_value_valid,
   output value_t  o_value
);

   value_t value_d;

   // anything that is not a hex digit reads as zero
   function automatic logic [3:0] hex_nibble(input byte_t c);
      logic [3:0] n;
      n = 4'h0;
      if (c >= "0" && c <= "9") begin
         n = 4'(c - CHAR_ZERO);
      end else if (c >= "a" && c <= "f") begin
         n = 4'(c - "a" + 8'd10);
      end else if (c >= "A" && c <= "F") begin
         n = 4'(c - "A" + 8'd10);
      end
      return n;
   endfunction

   // oldest character lands in the top nibble
   always_comb begin
      for (int i = 0; i < NUM_CHARS; i++) begin
         value_d[4*i +: 4] = hex_nibble(i_window[8*i +: 8]);
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_value_valid <= 1'b0;
         o_value       <= '0;
      end else begin
         o_value_valid <= i_line_ready;
         if (i_line_ready) begin
            o_value <= value_d;
         end
      end
   end

   a_valid_follows_ready : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      i_line_ready |=> o_value_valid
   );

endmodule

// ==== logic/ascii_line_buffer.sv ====
module ascii_line_buffer
   import ble_rx_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_byte_done,
   input  byte_t   i_byte,
   output logic    o_line_ready,
   output window_t o_window
);

   window_t window_q;
   logic    is_cr;
   logic    is_lf;

   assign is_cr = (i_byte == CHAR_CR);
   assign is_lf = (i_byte == CHAR_LF);

   // ****************************************
   // character window
   // ****************************************

   // newest character sits in the low byte
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         window_q <= {NUM_CHARS{CHAR_ZERO}};
      end else if (o_line_ready) begin
         // refill after release, short lines come out zero padded
         window_q <= {NUM_CHARS{CHAR_ZERO}};
      end else if (i_byte_done && !is_cr && !is_lf) begin
         window_q <= {window_q[(NUM_CHARS-1)*8-1:0], i_byte};
      end
   end

   // ****************************************
   // line release
   // ****************************************

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_line_ready <= 1'b0;
      end else begin
         o_line_ready <= i_byte_done && is_cr;
      end
   end

   // held until the next carriage return
   always_ff @(posedge clk) begin
      if (i_byte_done && is_cr) begin
         o_window <= window_q;
      end
   end

endmodule

// ==== logic/baud_tick_gen.sv ====
module baud_tick_gen
   import ble_rx_pkg::*;
(
   input  logic clk,
   input  logic i_rst_n,
   output logic o_tick
);

   logic [DIV_W-1:0] div_cnt;

   // down counter, reload on zero
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         div_cnt <= DIV_W'(BAUD_DIVISOR - 1);
      end else if (div_cnt == '0) begin
         div_cnt <= DIV_W'(BAUD_DIVISOR - 1);
      end else begin
         div_cnt <= div_cnt - 1'b1;
      end
   end

   assign o_tick = (div_cnt == '0);

   // ****************************************
   // checks
   // ****************************************

   // divisor above one keeps ticks apart
   a_tick_single_cycle : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      o_tick |=> !o_tick
   );

endmodule

// ==== logic/ble_rx_pkg.sv ====
package ble_rx_pkg;

   // ****************************************
   // serial timing
   // ****************************************

   // 16x oversampling tick for 115200 baud from a 50 MHz clock
   localparam int BAUD_DIVISOR = 27;
   localparam int DIV_W        = 5;
   localparam int OVERSAMPLE   = 16;
   localparam int DATA_BITS    = 8;

   // counter widths inside the receiver
   localparam int TICK_W = $clog2(OVERSAMPLE);
   localparam int BIT_W  = $clog2(DATA_BITS);

   // ****************************************
   // line format
   // ****************************************

   localparam int NUM_CHARS = 8;

   typedef logic [7:0]             byte_t;
   typedef logic [NUM_CHARS*8-1:0] window_t;
   typedef logic [NUM_CHARS*4-1:0] value_t;

   localparam byte_t CHAR_CR   = 8'h0D;
   localparam byte_t CHAR_LF   = 8'h0A;
   localparam byte_t CHAR_ZERO = 8'h30;

endpackage

// ==== logic/ble_telemetry_rx.sv ====
module ble_telemetry_rx
   import ble_rx_pkg::*;
(
   input  logic   clk,
   input  logic   i_rst_n,
   input  logic   i_rx,
   output logic   o_value_valid,
   output value_t o_value,
   output logic   o_frame_err
);

   logic    tick;
   logic    byte_done;
   byte_t   rx_byte;
   logic    line_ready;
   window_t window;

   // ****************************************
   // serial front end
   // ****************************************

   baud_tick_gen u_baud_tick_gen (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .o_tick  (tick)
   );

   uart_byte_rx u_uart_byte_rx (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_rx        (i_rx),
      .i_tick      (tick),
      .o_byte_done (byte_done),
      .o_byte      (rx_byte),
      .o_frame_err (o_frame_err)
   );

   // ****************************************
   // ascii line to value
   // ****************************************

   ascii_line_buffer u_ascii_line_buffer (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_byte_done  (byte_done),
      .i_byte       (rx_byte),
      .o_line_ready (line_ready),
      .o_window     (window)
   );

   // value_valid lands two cycles after the CR byte
   ascii_hex_decode u_ascii_hex_decode (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_line_ready  (line_ready),
      .i_window      (window),
      .o_value_valid (o_value_valid),
      .o_value       (o_value)
   );

endmodule

// ==== logic/uart_byte_rx.sv ====
module uart_byte_rx
   import ble_rx_pkg::*;
(
   input  logic  clk,
   input  logic  i_rst_n,
   input  logic  i_rx,
   input  logic  i_tick,
   output logic  o_byte_done,
   output byte_t o_byte,
   output logic  o_frame_err
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_START,
      ST_DATA,
      ST_STOP
   } state_t;

   state_t            state;
   logic              rx_meta;
   logic              rx_sync;
   logic              rx_prev;
   logic [TICK_W-1:0] tick_cnt;
   logic [BIT_W-1:0]  bit_cnt;
   byte_t             shift_q;

   // ****************************************
   // input synchronizer
   // ****************************************

   // line idles high
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   // ****************************************
   // frame FSM
   // ****************************************

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state       <= ST_IDLE;
         tick_cnt    <= '0;
         bit_cnt     <= '0;
         o_byte_done <= 1'b0;
         o_frame_err <= 1'b0;
      end else begin
         o_byte_done <= 1'b0;
         o_frame_err <= 1'b0;
         case (state)
            ST_IDLE: begin
               // falling edge only, so a held-low line after a bad stop is ignored
               if (rx_prev && !rx_sync) begin
                  state    <= ST_START;
                  tick_cnt <= '0;
               end
            end
            ST_START: begin
               if (i_tick) begin
                  if (tick_cnt == TICK_W'(OVERSAMPLE / 2 - 1)) begin
                     // glitch if the start bit is gone at mid-bit
                     state    <= rx_sync ? ST_IDLE : ST_DATA;
                     tick_cnt <= '0;
                     bit_cnt  <= '0;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            ST_DATA: begin
               if (i_tick) begin
                  if (tick_cnt == TICK_W'(OVERSAMPLE - 1)) begin
                     tick_cnt <= '0;
                     if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                        state <= ST_STOP;
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                     end
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            ST_STOP: begin
               if (i_tick) begin
                  if (tick_cnt == TICK_W'(OVERSAMPLE - 1)) begin
                     state       <= ST_IDLE;
                     tick_cnt    <= '0;
                     o_byte_done <= rx_sync;
                     o_frame_err <= !rx_sync;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk) begin
      if (state == ST_DATA && i_tick && tick_cnt == TICK_W'(OVERSAMPLE - 1)) begin
         shift_q <= {rx_sync, shift_q[7:1]};
      end
      if (state == ST_STOP && i_tick && tick_cnt == TICK_W'(OVERSAMPLE - 1) && rx_sync) begin
         o_byte <= shift_q;
      end
   end

   a_done_err_exclusive : assert property (
      @(posedge clk) disable iff (!i_rst_n)
      !(o_byte_done && o_frame_err)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up
verilator --binary --timing --assert -f tb.f --top-module tb_ble_telemetry_rx \
   && ./obj_dir/Vtb_ble_telemetry_rx | tee /dev/stderr | grep -q "Regression passed" \
   && echo "simulation PASSED" \
   || { echo "simulation FAILED"; exit 1; }

// ==== tb.f ====
logic/ble_rx_pkg.sv
logic/baud_tick_gen.sv
logic/uart_byte_rx.sv
logic/ascii_line_buffer.sv
logic/ascii_hex_decode.sv
logic/ble_telemetry_rx.sv
test/tb_ble_telemetry_rx.sv

// ==== test/tb_ble_telemetry_rx.sv ====
module tb_ble_telemetry_rx
   import ble_rx_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int BIT_CYCLES = OVERSAMPLE * BAUD_DIVISOR;
   localparam int WAIT_LIMIT = 2 * BIT_CYCLES;
   localparam int RNG_SEED   = 94612;

   logic   clk;
   logic   rst_n;
   logic   rx;
   logic   value_valid;
   value_t value;
   logic   frame_err;

   value_t exp_values[$];
   string  exp_names[$];
   value_t popped_value;
   string  popped_name;
   int     errors          = 0;
   int     value_count     = 0;
   int     frame_err_count = 0;
   int     lines_sent      = 0;
   int     frames_bad      = 0;

   ble_telemetry_rx i_dut (
      .clk           (clk),
      .i_rst_n       (rst_n),
      .i_rx          (rx),
      .o_value_valid (value_valid),
      .o_value       (value),
      .o_frame_err   (frame_err)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ****************************************
   // reference model
   // ****************************************

   function automatic logic [3:0] nibble_of(input byte_t c);
      byte_t      folded;
      logic [3:0] n;
      // upper and lower case letters fold together
      folded = c | 8'h20;
      n = 4'h0;
      if (c >= 8'h30 && c <= 8'h39) begin
         n = c[3:0];
      end else if (folded >= 8'h61 && folded <= 8'h66) begin
         n = c[3:0] + 4'd9;
      end
      return n;
   endfunction

   // window starts as all '0', so shifting nibbles in from zero is the same thing
   function automatic value_t ref_value(input string s);
      value_t v;
      byte_t  c;
      v = '0;
      for (int i = 0; i < s.len(); i++) begin
         c = s[i];
         if (c != CHAR_LF && c != CHAR_CR) begin
            v = {v[NUM_CHARS*4-5:0], nibble_of(c)};
         end
      end
      return v;
   endfunction

   // random upper or lower case per letter
   function automatic string hex_text(input value_t v);
      string      s;
      logic [3:0] nib;
      byte_t      c;
      s = "";
      for (int i = NUM_CHARS - 1; i >= 0; i--) begin
         nib = v[4*i +: 4];
         if (nib < 4'd10) begin
            c = 8'h30 + {4'h0, nib};
         end else if ($urandom_range(1, 0) == 1) begin
            c = 8'h41 + {4'h0, nib} - 8'd10;
         end else begin
            c = 8'h61 + {4'h0, nib} - 8'd10;
         end
         s = $sformatf("%s%c", s, c);
      end
      return s;
   endfunction

   // ****************************************
   // serial driver and waits
   // ****************************************

   task automatic send_byte(input byte_t b, input bit bad_stop);
      @(negedge clk);
      rx = 1'b0;
      repeat (BIT_CYCLES) @(negedge clk);
      for (int i = 0; i < DATA_BITS; i++) begin
         rx = b[i];
         repeat (BIT_CYCLES) @(negedge clk);
      end
      rx = !bad_stop;
      repeat (BIT_CYCLES) @(negedge clk);
      rx = 1'b1;
      // idle gap so the next start bit is a real falling edge
      if (bad_stop) begin
         repeat (BIT_CYCLES) @(negedge clk);
      end
   endtask

   task automatic wait_values(input int target, input string name);
      int cycles;
      cycles = 0;
      while (value_count < target && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      assert (value_count >= target) else begin
         errors++;
         $display("%s: no value_valid within %0d cycles after the CR", name, WAIT_LIMIT);
      end
   endtask

   task automatic wait_frame_errs(input int target, input string name);
      int cycles;
      cycles = 0;
      while (frame_err_count < target && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      assert (frame_err_count == target) else begin
         errors++;
         $display("%s: expected %0d framing errors so far, saw %0d", name, target,
                  frame_err_count);
      end
   endtask

   // bad_idx marks the character sent with a low stop bit, -1 for none
   task automatic run_line(input string name, input string s, input int bad_idx);
      string delivered;
      delivered = "";
      for (int i = 0; i < s.len(); i++) begin
         if (i != bad_idx) begin
            delivered = $sformatf("%s%c", delivered, s[i]);
         end
      end
      exp_values.push_back(ref_value(delivered));
      exp_names.push_back(name);
      lines_sent++;
      if (bad_idx >= 0) begin
         frames_bad++;
      end
      for (int i = 0; i < s.len(); i++) begin
         send_byte(s[i], i == bad_idx);
      end
      send_byte(CHAR_CR, 1'b0);
      wait_values(lines_sent, name);
      wait_frame_errs(frames_bad, name);
   endtask

   // ****************************************
   // checker
   // ****************************************

   // outputs are stable mid-cycle
   always @(negedge clk) begin
      if (rst_n) begin
         if (value_valid) begin
            value_count++;
            assert (exp_values.size() != 0) else begin
               errors++;
               $display("value_valid pulsed with no line pending, value %h", value);
            end
            if (exp_values.size() != 0) begin
               popped_value = exp_values.pop_front();
               popped_name  = exp_names.pop_front();
               assert (value == popped_value) else begin
                  errors++;
                  $display("FAILED %s: expected %h, actual %h", popped_name, popped_value, value);
               end
            end
         end
         if (frame_err) begin
            frame_err_count++;
         end
      end
   end

   // ****************************************
   // test sequence
   // ****************************************

   initial begin
      void'($urandom(RNG_SEED));
      rst_n = 1'b0;
      rx    = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // quiet line after reset
      repeat (4 * BIT_CYCLES) @(posedge clk);
      assert (value_count == 0 && frame_err_count == 0 && value == '0) else begin
         errors++;
         $display("outputs moved while the serial line was idle after reset");
      end

      for (int n = 0; n < 10; n++) begin
         run_line($sformatf("random_%0d", n), hex_text(value_t'($urandom)), -1);
      end

      run_line("short_line", "472", -1);
      run_line("long_line", "12345678901", -1);

      // leading LF here is the tail of the CR LF ending the previous line
      run_line("non_hex", "7f3Gk2e1", -1);
      run_line("after_lf", "\n5", -1);

      run_line("bad_stop", "1273", 2);

      repeat (BIT_CYCLES) @(posedge clk);
      assert (exp_values.size() == 0) else begin
         errors++;
         $display("%0d lines were sent but never decoded", exp_values.size());
      end

      $display("errors: %0d, values checked: %0d, framing errors seen: %0d",
               errors, value_count, frame_err_count);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
